// File: Bender.yml
package:
  name: tap

sources:
  # Packages first, then the RTL
  - files:
      - verilog/tap_pkg.sv
      - verilog/tdr_pkg.sv
      - verilog/tap_fsm.sv
      - verilog/instruction_reg.sv
      - verilog/scan_register.sv
      - verilog/bist_timer.sv
      - verilog/tap_top.sv

  # Testbench, top module tap_tb
  - target: test
    files:
      - tb/tap_tb.sv

// File: flist.f
verilog/tap_pkg.sv
verilog/tdr_pkg.sv
verilog/tap_fsm.sv
verilog/instruction_reg.sv
verilog/scan_register.sv
verilog/bist_timer.sv
verilog/tap_top.sv
tb/tap_tb.sv

// File: tb/tap_tb.sv
/* Testbench for tap_top with the user TDR output looped back to its input.
   Inputs change on the falling edge of tck and TDO is sampled on the rising edge. */

`timescale 1ns/1ns

module tap_tb;

    import tap_pkg::*;
    import tdr_pkg::*;

    // Tests take about 270 cycles and the rest is margin
    localparam int MAX_CYCLES = 2000;

    logic    tck = 1'b0;
    logic    reset;
    logic    tms;
    logic    tdi;
    logic    tdo;
    logic    tdo_en;
    logic    bist_run;
    logic    bist_done;
    idcode_t idcode_val;
    wire tdr_t tdr_loop;

    // Reference model state
    ir_t         model_ir;
    tdr_t        model_tdr;
    logic        model_done;
    logic [31:0] lfsr = 32'h767d;

    // Pending comparisons
    string       name_q[$];
    logic [63:0] exp_q[$];
    logic [63:0] got_q[$];
    int          pushed = 0;
    int          compared = 0;

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int errors_at_start = 0;
    int tests = 0;
    int failed_tests = 0;

    tap_top #(.BIST_CYCLES(20)) dut (
        .tck          (tck),
        .reset        (reset),
        .tms          (tms),
        .tdi          (tdi),
        .tdo          (tdo),
        .tdo_en       (tdo_en),
        .idcode       (idcode_val),
        .tdr_data_in  (tdr_loop),
        .tdr_data_out (tdr_loop),
        .bist_run     (bist_run),
        .bist_done    (bist_done)
    );

    // 40 ns period
    always #20 tck = ~tck;

    always @(posedge tck) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d tck cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ------------------------------
    // Random bits and reference
    // ------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    // Captured bits leave first, then the shifted-in stream follows
    function automatic logic [63:0] expected_dr(input ir_t instr, input idcode_t id,
            input tdr_t tdr, input logic done, input logic [63:0] din, input int len);
        logic [63:0] cap;
        logic [63:0] r;
        int          cap_w;
        cap = '0;
        r   = '0;
        case (instr)
            OP_IDCODE: begin
                cap   = id;
                cap_w = IDCODE_WIDTH;
            end
            OP_USER_TDR: begin
                cap   = tdr;
                cap_w = TDR_WIDTH;
            end
            OP_RUNBIST: begin
                cap   = done;
                cap_w = 1;
            end
            // Bypass and every undefined opcode
            default: cap_w = 1;
        endcase
        for (int i = 0; i < len; i++) begin
            r[i] = (i < cap_w) ? cap[i] : din[i - cap_w];
        end
        return r;
    endfunction

    // ------------------------------
    // Checking
    // ------------------------------

    task automatic compare_values(input string name, input logic [63:0] e,
            input logic [63:0] g);
        checks++;
        if (g !== e) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h actual %h", $time, name, e, g);
        end
    endtask

    task automatic expect_value(input string name, input logic [63:0] e,
            input logic [63:0] g);
        name_q.push_back(name);
        exp_q.push_back(e);
        got_q.push_back(g);
        pushed++;
    endtask

    // Comparator works through the pending results in order
    initial begin
        forever begin
            wait (compared != pushed);
            compare_values(name_q[compared], exp_q[compared], got_q[compared]);
            compared++;
        end
    end

    task automatic finish_test(input string name);
        wait (compared == pushed);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed", tests, name);
        end
        errors_at_start = errors;
    endtask

    // ------------------------------
    // JTAG drive
    // ------------------------------

    // Starts at a falling edge and returns at the next one
    task automatic clock_tap(input logic tms_v, input logic tdi_v, input logic exp_en,
            output logic tdo_bit);
        tms = tms_v;
        tdi = tdi_v;
        @(posedge tck);
        tdo_bit = tdo;
        if (tdo_en !== exp_en) begin
            errors++;
            if (exp_en) begin
                $display("tdo_en low during shift at %0t ns", $time);
            end else begin
                $display("tdo_en high outside a shift state at %0t ns", $time);
            end
        end
        @(negedge tck);
    endtask

    // From Run-Test/Idle back to Run-Test/Idle
    task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
        logic b;
        dout = '0;
        clock_tap(1, 0, 0, b);
        clock_tap(0, 0, 0, b);
        // Capture-DR to Shift-DR
        clock_tap(0, 0, 0, b);
        for (int i = 0; i < len; i++) begin
            clock_tap(i == len - 1, din[i], 1, b);
            dout[i] = b;
        end
        // Exit1-DR, Update-DR, then idle
        clock_tap(1, 0, 0, b);
        clock_tap(0, 0, 0, b);
    endtask

    task automatic scan_ir(input ir_t instr, output ir_t dout);
        logic b;
        clock_tap(1, 0, 0, b);
        clock_tap(1, 0, 0, b);
        clock_tap(0, 0, 0, b);
        clock_tap(0, 0, 0, b);
        for (int i = 0; i < IR_WIDTH; i++) begin
            clock_tap(i == IR_WIDTH - 1, instr[i], 1, b);
            dout[i] = b;
        end
        clock_tap(1, 0, 0, b);
        clock_tap(0, 0, 0, b);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        logic [63:0] din;
        logic [63:0] dout;
        logic [63:0] exp;
        ir_t         ir_out;
        logic        b;
        reset = 1'b1;
        tms   = 1'b1;
        tdi   = 1'b0;
        take_random(32, din);
        // Bit 0 of an IDCODE is always 1
        idcode_val = {din[31:1], 1'b1};
        repeat (16) @(negedge tck);
        reset      = 1'b0;
        model_ir   = OP_IDCODE;
        model_tdr  = '0;
        model_done = 1'b0;

        clock_tap(0, 0, 0, b);
        take_random(32, din);
        scan_dr(32, din, dout);
        expect_value("tdo", expected_dr(model_ir, idcode_val, model_tdr, model_done, din, 32),
            dout);
        finish_test("idcode after reset");

        scan_ir(OP_BYPASS, ir_out);
        model_ir = OP_BYPASS;
        // Capture pattern 0101 leaves LSB first
        expect_value("tdo", 4'b0101, ir_out);
        finish_test("ir capture");

        take_random(24, din);
        scan_dr(24, din, dout);
        expect_value("tdo", expected_dr(model_ir, idcode_val, model_tdr, model_done, din, 24),
            dout);
        // Undefined opcode falls back to bypass
        scan_ir(4'h3, ir_out);
        model_ir = 4'h3;
        take_random(24, din);
        scan_dr(24, din, dout);
        expect_value("tdo", expected_dr(model_ir, idcode_val, model_tdr, model_done, din, 24),
            dout);
        finish_test("bypass");

        scan_ir(OP_USER_TDR, ir_out);
        model_ir = OP_USER_TDR;
        take_random(16, din);
        exp = expected_dr(model_ir, idcode_val, model_tdr, model_done, din, 16);
        scan_dr(16, din, dout);
        expect_value("tdo", exp, dout);
        model_tdr = din[15:0];
        expect_value("tdr_data_out", model_tdr, tdr_loop);
        // Loopback brings the updated value back in at Capture-DR
        take_random(16, din);
        exp = expected_dr(model_ir, idcode_val, model_tdr, model_done, din, 16);
        scan_dr(16, din, dout);
        expect_value("tdo", exp, dout);
        model_tdr = din[15:0];
        expect_value("tdr_data_out", model_tdr, tdr_loop);
        finish_test("user tdr");

        scan_ir(OP_RUNBIST, ir_out);
        model_ir = OP_RUNBIST;
        repeat (19) clock_tap(0, 0, 0, b);
        expect_value("bist_run", 1'b1, bist_run);
        expect_value("bist_done", 1'b0, bist_done);
        clock_tap(0, 0, 0, b);
        model_done = 1'b1;
        expect_value("bist_run", 1'b0, bist_run);
        expect_value("bist_done", 1'b1, bist_done);
        take_random(1, din);
        scan_dr(1, din, dout);
        expect_value("tdo", expected_dr(model_ir, idcode_val, model_tdr, model_done, din, 1),
            dout);
        // Any instruction load clears the result
        scan_ir(OP_BYPASS, ir_out);
        model_ir   = OP_BYPASS;
        model_done = 1'b0;
        expect_value("bist_done", model_done, bist_done);
        finish_test("runbist");

        // Into Shift-DR, then five TMS-high edges
        clock_tap(1, 0, 0, b);
        clock_tap(0, 0, 0, b);
        clock_tap(0, 0, 0, b);
        clock_tap(1, 0, 1, b);
        repeat (4) clock_tap(1, 0, 0, b);
        model_ir = OP_IDCODE;
        clock_tap(0, 0, 0, b);
        take_random(32, din);
        scan_dr(32, din, dout);
        expect_value("tdo", expected_dr(model_ir, idcode_val, model_tdr, model_done, din, 32),
            dout);
        expect_value("tdr_data_out", model_tdr, tdr_loop);
        finish_test("tms reset");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verilog/bist_timer.sv
/* RUNBIST timer counting TCK cycles in Run-Test/Idle.
   bist_done stays set until the next Update-IR; the count holds outside Run-Test/Idle. */

`timescale 1ns/1ns

module bist_timer #(
    parameter int unsigned BIST_CYCLES = 20
) (
    input  logic tck,
    input  logic reset,
    input  logic rti,
    input  logic sel_runbist,
    input  logic update_ir,
    output logic bist_run,
    output logic bist_done
);

    // Wide enough to hold BIST_CYCLES itself
    localparam int CNT_W = $clog2(BIST_CYCLES + 1);

    logic [CNT_W-1:0] count;
    logic             advance;

    // Count only while the test is running
    assign advance = rti && sel_runbist && !bist_done;

    always_ff @(posedge tck) begin
        if (reset || update_ir) begin
            // Every instruction load starts a fresh count
            count     <= '0;
            bist_done <= 1'b0;
        end else if (advance) begin
            count <= count + 1'b1;
            // Done on the edge where the count reaches BIST_CYCLES
            if (count == CNT_W'(BIST_CYCLES - 1)) begin
                bist_done <= 1'b1;
            end
        end
    end

    assign bist_run = sel_runbist && !bist_done;

endmodule

// File: verilog/instruction_reg.sv
/* Instruction shift/update register and decode into one-hot register selects.
   Undefined opcodes select the bypass register. */

`timescale 1ns/1ns

module instruction_reg (
    input  logic                tck,
    input  logic                reset,
    input  tap_pkg::tap_state_t state,
    input  logic                tdi,
    input  logic                capture_ir,
    input  logic                shift_ir,
    input  logic                update_ir,
    output logic                ir_so,
    output logic                sel_idcode,
    output logic                sel_user_tdr,
    output logic                sel_runbist,
    output logic                sel_bypass
);

    import tap_pkg::*;

    // Shift stage and active instruction
    ir_t ir_shift;
    ir_t ir_active;

    // ------------------------------
    // Shift stage
    // ------------------------------

    // Capture loads the fixed pattern, shift moves toward the LSB
    always_ff @(posedge tck) begin
        if (capture_ir) begin
            ir_shift <= IR_CAPTURE;
        end else if (shift_ir) begin
            ir_shift <= {tdi, ir_shift[IR_WIDTH-1:1]};
        end
    end

    // LSB leaves first
    assign ir_so = ir_shift[0];

    // ------------------------------
    // Update stage
    // ------------------------------

    // Test-Logic-Reset reached by TMS acts like reset here
    always_ff @(posedge tck) begin
        if (reset || state == ST_TEST_LOGIC_RESET) begin
            ir_active <= OP_IDCODE;
        end else if (update_ir) begin
            ir_active <= ir_shift;
        end
    end

    // Decode, exactly one select high
    always_comb begin
        sel_idcode   = 1'b0;
        sel_user_tdr = 1'b0;
        sel_runbist  = 1'b0;
        sel_bypass   = 1'b0;
        case (ir_active)
            OP_IDCODE:   sel_idcode   = 1'b1;
            OP_USER_TDR: sel_user_tdr = 1'b1;
            OP_RUNBIST:  sel_runbist  = 1'b1;
            OP_BYPASS:   sel_bypass   = 1'b1;
            // Undefined opcodes fall back to bypass
            default:     sel_bypass   = 1'b1;
        endcase
    end

endmodule

// File: verilog/scan_register.sv
/* Capture/shift/update data register, width taken from the payload type.
   Strobes must already be gated with the register select. */

`timescale 1ns/1ns

module scan_register #(
    parameter type payload_t = tdr_pkg::tdr_t
) (
    input  logic     tck,
    input  logic     reset,
    input  logic     capture,
    input  logic     shift,
    input  logic     update,
    input  logic     tdi,
    input  payload_t capture_value,
    output logic     so,
    output payload_t update_value
);

    localparam int WIDTH = $bits(payload_t);

    payload_t shift_q;

    // ------------------------------
    // Shift stage
    // ------------------------------

    // Parallel load on capture, else shift right with tdi at the MSB
    always_ff @(posedge tck) begin
        if (capture) begin
            shift_q <= capture_value;
        end else if (shift) begin
            shift_q <= {tdi, shift_q[WIDTH-1:1]};
        end
    end

    assign so = shift_q[0];

    // ------------------------------
    // Update stage
    // ------------------------------

    // Holds its value through Test-Logic-Reset reached by TMS
    always_ff @(posedge tck) begin
        if (reset) begin
            update_value <= '0;
        end else if (update) begin
            update_value <= shift_q;
        end
    end

endmodule

// File: verilog/tap_fsm.sv
/* 1149.1 TAP controller with decoded state strobes.
   Synchronous reset replaces TRST; five TMS-high edges also reach Test-Logic-Reset. */

`timescale 1ns/1ns

module tap_fsm (
    input  logic                tck,
    input  logic                reset,
    input  logic                tms,
    output tap_pkg::tap_state_t state,
    output logic                capture_dr,
    output logic                shift_dr,
    output logic                update_dr,
    output logic                capture_ir,
    output logic                shift_ir,
    output logic                update_ir,
    output logic                rti
);

    import tap_pkg::*;

    tap_state_t next_state;

    // ------------------------------
    // Transition table
    // ------------------------------

    always_comb begin
        next_state = state;
        case (state)
            ST_TEST_LOGIC_RESET: next_state = tms ? ST_TEST_LOGIC_RESET : ST_RUN_TEST_IDLE;
            ST_RUN_TEST_IDLE:    next_state = tms ? ST_SELECT_DR_SCAN   : ST_RUN_TEST_IDLE;

            // DR column
            ST_SELECT_DR_SCAN:   next_state = tms ? ST_SELECT_IR_SCAN   : ST_CAPTURE_DR;
            ST_CAPTURE_DR:       next_state = tms ? ST_EXIT1_DR         : ST_SHIFT_DR;
            ST_SHIFT_DR:         next_state = tms ? ST_EXIT1_DR         : ST_SHIFT_DR;
            ST_EXIT1_DR:         next_state = tms ? ST_UPDATE_DR        : ST_PAUSE_DR;
            ST_PAUSE_DR:         next_state = tms ? ST_EXIT2_DR         : ST_PAUSE_DR;
            ST_EXIT2_DR:         next_state = tms ? ST_UPDATE_DR        : ST_SHIFT_DR;
            ST_UPDATE_DR:        next_state = tms ? ST_SELECT_DR_SCAN   : ST_RUN_TEST_IDLE;

            // IR column, TMS high in Select-IR-Scan leaves to reset
            ST_SELECT_IR_SCAN:   next_state = tms ? ST_TEST_LOGIC_RESET : ST_CAPTURE_IR;
            ST_CAPTURE_IR:       next_state = tms ? ST_EXIT1_IR         : ST_SHIFT_IR;
            ST_SHIFT_IR:         next_state = tms ? ST_EXIT1_IR         : ST_SHIFT_IR;
            ST_EXIT1_IR:         next_state = tms ? ST_UPDATE_IR        : ST_PAUSE_IR;
            ST_PAUSE_IR:         next_state = tms ? ST_EXIT2_IR         : ST_PAUSE_IR;
            ST_EXIT2_IR:         next_state = tms ? ST_UPDATE_IR        : ST_SHIFT_IR;
            ST_UPDATE_IR:        next_state = tms ? ST_SELECT_DR_SCAN   : ST_RUN_TEST_IDLE;

            default:             next_state = ST_TEST_LOGIC_RESET;
        endcase
    end

    // ------------------------------
    // State register
    // ------------------------------

    always_ff @(posedge tck) begin
        if (reset) begin
            state <= ST_TEST_LOGIC_RESET;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------
    // Decoded strobes
    // ------------------------------

    // High for the whole cycle spent in the state
    // The action happens on the rising edge that ends that cycle
    assign capture_dr = (state == ST_CAPTURE_DR);
    assign shift_dr   = (state == ST_SHIFT_DR);
    assign update_dr  = (state == ST_UPDATE_DR);

    assign capture_ir = (state == ST_CAPTURE_IR);
    assign shift_ir   = (state == ST_SHIFT_IR);
    assign update_ir  = (state == ST_UPDATE_IR);

    // Run-Test/Idle, used by the BIST timer
    assign rti        = (state == ST_RUN_TEST_IDLE);

endmodule

// File: verilog/tap_pkg.sv
/* TAP controller state encoding and 4-bit instruction set.
   Any opcode not listed here decodes to BYPASS. */

package tap_pkg;

    // ------------------------------
    // Controller states
    // ------------------------------

    // Encoding follows the common 1149.1 state assignment
    typedef enum logic [3:0] {
        ST_EXIT2_DR         = 4'h0,
        ST_EXIT1_DR         = 4'h1,
        ST_SHIFT_DR         = 4'h2,
        ST_PAUSE_DR         = 4'h3,
        ST_SELECT_IR_SCAN   = 4'h4,
        ST_UPDATE_DR        = 4'h5,
        ST_CAPTURE_DR       = 4'h6,
        ST_SELECT_DR_SCAN   = 4'h7,
        ST_EXIT2_IR         = 4'h8,
        ST_EXIT1_IR         = 4'h9,
        ST_SHIFT_IR         = 4'hA,
        ST_PAUSE_IR         = 4'hB,
        ST_RUN_TEST_IDLE    = 4'hC,
        ST_UPDATE_IR        = 4'hD,
        ST_CAPTURE_IR       = 4'hE,
        ST_TEST_LOGIC_RESET = 4'hF
    } tap_state_t;

    // ------------------------------
    // Instructions
    // ------------------------------

    localparam int IR_WIDTH = 4;

    typedef logic [IR_WIDTH-1:0] ir_t;

    // Reset instruction, also reloaded in Test-Logic-Reset
    localparam ir_t OP_IDCODE   = 4'h1;
    localparam ir_t OP_USER_TDR = 4'h8;
    localparam ir_t OP_RUNBIST  = 4'h9;
    // All ones, as 1149.1 requires for BYPASS
    localparam ir_t OP_BYPASS   = 4'hF;

    // Loaded in Capture-IR, the two LSBs are the mandatory 01
    localparam ir_t IR_CAPTURE  = 4'b0101;

endpackage

// File: verilog/tap_top.sv
/* 1149.1 TAP with IDCODE, user TDR, RUNBIST and BYPASS.
   TDO and tdo_en change on the falling edge of tck; no boundary scan. */

`timescale 1ns/1ns

module tap_top #(
    parameter int unsigned BIST_CYCLES = 20
) (
    input  logic             tck,
    input  logic             reset,
    input  logic             tms,
    input  logic             tdi,
    output logic             tdo,
    output logic             tdo_en,
    input  tdr_pkg::idcode_t idcode,
    input  tdr_pkg::tdr_t    tdr_data_in,
    output tdr_pkg::tdr_t    tdr_data_out,
    output logic             bist_run,
    output logic             bist_done
);

    import tap_pkg::*;
    import tdr_pkg::*;

    tap_state_t state;
    logic       capture_dr, shift_dr, update_dr;
    logic       capture_ir, shift_ir, update_ir;
    logic       rti;
    logic       ir_so;
    logic       sel_idcode, sel_user_tdr, sel_runbist, sel_bypass;
    logic       idcode_so, user_tdr_so;
    logic       bypass_q;
    logic       bist_status_q;
    logic       dr_so;

    // ------------------------------
    // Controller and instruction
    // ------------------------------

    tap_fsm u_tap_fsm (
        .tck        (tck),
        .reset      (reset),
        .tms        (tms),
        .state      (state),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .rti        (rti)
    );

    instruction_reg u_instruction_reg (
        .tck          (tck),
        .reset        (reset),
        .state        (state),
        .tdi          (tdi),
        .capture_ir   (capture_ir),
        .shift_ir     (shift_ir),
        .update_ir    (update_ir),
        .ir_so        (ir_so),
        .sel_idcode   (sel_idcode),
        .sel_user_tdr (sel_user_tdr),
        .sel_runbist  (sel_runbist),
        .sel_bypass   (sel_bypass)
    );

    // ------------------------------
    // Data registers
    // ------------------------------

    // IDCODE is read only and its update stage has no load
    scan_register #(.payload_t(idcode_t)) idcode_reg (
        .tck           (tck),
        .reset         (reset),
        .capture       (capture_dr && sel_idcode),
        .shift         (shift_dr && sel_idcode),
        .update        (update_dr && sel_idcode),
        .tdi           (tdi),
        .capture_value (idcode),
        .so            (idcode_so),
        .update_value  ()
    );

    scan_register #(.payload_t(tdr_t)) user_tdr_reg (
        .tck           (tck),
        .reset         (reset),
        .capture       (capture_dr && sel_user_tdr),
        .shift         (shift_dr && sel_user_tdr),
        .update        (update_dr && sel_user_tdr),
        .tdi           (tdi),
        .capture_value (tdr_data_in),
        .so            (user_tdr_so),
        .update_value  (tdr_data_out)
    );

    bist_timer #(.BIST_CYCLES(BIST_CYCLES)) u_bist_timer (
        .tck         (tck),
        .reset       (reset),
        .rti         (rti),
        .sel_runbist (sel_runbist),
        .update_ir   (update_ir),
        .bist_run    (bist_run),
        .bist_done   (bist_done)
    );

    // Bypass bit captures 0 and shifts only while BYPASS is selected
    always_ff @(posedge tck) begin
        if (capture_dr && sel_bypass) begin
            bypass_q <= 1'b0;
        end else if (shift_dr && sel_bypass) begin
            bypass_q <= tdi;
        end
    end

    // RUNBIST status bit captures bist_done
    always_ff @(posedge tck) begin
        if (capture_dr && sel_runbist) begin
            bist_status_q <= bist_done;
        end else if (shift_dr && sel_runbist) begin
            bist_status_q <= tdi;
        end
    end

    // Serial output of the selected data register
    always_comb begin
        if (sel_idcode) begin
            dr_so = idcode_so;
        end else if (sel_user_tdr) begin
            dr_so = user_tdr_so;
        end else if (sel_runbist) begin
            dr_so = bist_status_q;
        end else begin
            dr_so = bypass_q;
        end
    end

    // ------------------------------
    // TDO on the falling edge
    // ------------------------------

    // Bit 0 is out half a cycle after entering a shift state
    always_ff @(negedge tck) begin
        if (reset) begin
            tdo_en <= 1'b0;
        end else begin
            tdo_en <= shift_dr || shift_ir;
        end
    end

    always_ff @(negedge tck) begin
        tdo <= shift_ir ? ir_so : dr_so;
    end

endmodule

// File: verilog/tdr_pkg.sv
/* Widths and payload types of the data registers.
   The user TDR width sets the parallel port width at the top level. */

package tdr_pkg;

    // User test data register
    localparam int TDR_WIDTH = 16;

    typedef logic [TDR_WIDTH-1:0] tdr_t;

    // Device identification register, bit 0 must read 1 per 1149.1
    localparam int IDCODE_WIDTH = 32;

    typedef logic [IDCODE_WIDTH-1:0] idcode_t;

endpackage
